// File: bench/pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_tb
  import pipe_pkg::*;
();

  logic             clk;
  logic             rst_n;
  logic             in_valid_i;
  instr_t           in_instr_i;
  logic             in_ready_o;
  logic             retire_valid_o;
  opcode_t          retire_op_o;
  logic [REG_W-1:0] retire_rd_o;
  logic [XLEN-1:0]  retire_value_o;
  logic             retire_ready_i;

  // One expected retire whose value is the taken flag for skips
  typedef struct {
    opcode_t          op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  value;
  } retire_rec_t;

  retire_rec_t     exp_q[$];
  instr_t          prog_q[$];
  int              gap_q[$];
  // Architectural model that persists across tests like the DUT
  logic [XLEN-1:0] model_regs [NREG];
  logic            model_skip;
  integer          seed = 32'h753f2189;
  logic            bp_enable;
  logic            timed_out;
  int              err_count;
  int              tests_run;
  int              tests_bad;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pipe_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid_i),
    .in_instr_i     (in_instr_i),
    .in_ready_o     (in_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_op_o    (retire_op_o),
    .retire_rd_o    (retire_rd_o),
    .retire_value_o (retire_value_o),
    .retire_ready_i (retire_ready_i)
  );

  // Reference model runs prog_q in order and appends the expected retires
  function automatic void run_model();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    retire_rec_t     rec;
    foreach (prog_q[i]) begin
      a = model_regs[prog_q[i].rs1];
      b = model_regs[prog_q[i].rs2];
      rec.op = prog_q[i].op;
      rec.rd = prog_q[i].rd;
      if (model_skip) begin
        // Discarded by the taken skip just before it
        model_skip = 1'b0;
      end else begin
        case (prog_q[i].op)
          OP_ADD:  rec.value = a + b;
          OP_ADDI: rec.value = a + {8'h00, prog_q[i].imm8};
          OP_SUB:  rec.value = a - b;
          default: begin
            rec.value  = (a == b) ? 16'd1 : 16'd0;
            model_skip = (a == b);
          end
        endcase
        if (prog_q[i].op != OP_SKIPEQ) begin
          model_regs[rec.rd] = rec.value;
        end
        exp_q.push_back(rec);
      end
    end
  endfunction

  // Appends one instruction and its idle cycles before it
  function automatic void queue_instr(opcode_t op, logic [REG_W-1:0] rd,
                                      logic [REG_W-1:0] rs1, logic [REG_W-1:0] rs2,
                                      logic [7:0] imm, int gap);
    instr_t ins;
    ins.op   = op;
    ins.rd   = rd;
    ins.rs1  = rs1;
    ins.rs2  = rs2;
    ins.imm8 = imm;
    prog_q.push_back(ins);
    gap_q.push_back(gap);
  endfunction

  // Inputs change 2 ns after the rising edge and ready is sampled at the falling edge
  task automatic drive_program();
    int wait_cycles;
    @(posedge clk);
    #2;
    foreach (prog_q[i]) begin
      repeat (gap_q[i]) begin
        @(posedge clk);
        #2;
      end
      in_valid_i  = 1'b1;
      in_instr_i  = prog_q[i];
      wait_cycles = 0;
      // Word and valid held until accepted
      do begin
        @(negedge clk);
        wait_cycles++;
      end while (!in_ready_o && wait_cycles < 100);
      if (!in_ready_o) begin
        $display("Timeout: input port stayed not ready for %0d cycles at %0t",
                 wait_cycles, $time);
        timed_out  = 1'b1;
        in_valid_i = 1'b0;
        return;
      end
      @(posedge clk);
      #2;
      in_valid_i = 1'b0;
    end
  endtask

  // Pipeline drained once every expected retire was seen
  task automatic wait_drain();
    int wait_cycles;
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 400) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d expected retires still outstanding at %0t", exp_q.size(), $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic issue_and_drain();
    run_model();
    drive_program();
    if (!timed_out) begin
      wait_drain();
    end
    prog_q.delete();
    gap_q.delete();
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    if (err_count == errs_before && !timed_out) begin
      $display("[TEST] %s: ok", name);
    end else begin
      tests_bad++;
      $display("[TEST] %s: FAILED with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic reset_readback();
    // Outputs sampled mid-cycle
    @(negedge clk);
    if (retire_valid_o !== 1'b0) begin
      $display("[FAIL] %0t retire_valid_o: got %b, expected 0", $time, retire_valid_o);
      err_count++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("[FAIL] %0t in_ready_o: got %b, expected 1", $time, in_ready_o);
      err_count++;
    end
    // ADDI with zero immediate reads each register back
    for (int i = 0; i < NREG; i++) begin
      queue_instr(OP_ADDI, REG_W'(i), REG_W'(i), '0, 8'h00, 0);
    end
    issue_and_drain();
  endtask

  task automatic independent_stream();
    queue_instr(OP_ADDI, 1, 0, 0, 8'h12, 0);
    queue_instr(OP_ADDI, 2, 0, 0, 8'h34, 0);
    queue_instr(OP_ADDI, 3, 0, 0, 8'hff, 0);
    queue_instr(OP_ADD, 0, 1, 2, 8'h00, 3);
    queue_instr(OP_SUB, 2, 3, 1, 8'h00, 0);
    queue_instr(OP_ADDI, 1, 3, 0, 8'h01, 0);
    queue_instr(OP_SUB, 3, 0, 0, 8'h00, 2);
    issue_and_drain();
  endtask

  // Each one reads the previous result through the RAW stall
  task automatic dependent_chain();
    queue_instr(OP_ADDI, 1, 1, 0, 8'h05, 0);
    queue_instr(OP_ADD, 2, 1, 1, 8'h00, 0);
    queue_instr(OP_SUB, 3, 2, 1, 8'h00, 0);
    queue_instr(OP_ADD, 1, 3, 3, 8'h00, 0);
    queue_instr(OP_ADDI, 1, 1, 0, 8'hf0, 0);
    queue_instr(OP_SUB, 0, 0, 1, 8'h00, 0);
    queue_instr(OP_ADD, 0, 0, 0, 8'h00, 0);
    issue_and_drain();
  endtask

  task automatic skip_sequences();
    // Taken skip with the victim already in ID takes the flush path
    queue_instr(OP_ADDI, 1, 2, 0, 8'h00, 0);
    queue_instr(OP_SKIPEQ, 0, 1, 2, 8'h00, 0);
    queue_instr(OP_ADDI, 3, 3, 0, 8'h01, 0);
    queue_instr(OP_ADDI, 0, 0, 0, 8'h07, 0);
    // Not taken
    queue_instr(OP_SKIPEQ, 0, 0, 3, 8'h00, 2);
    queue_instr(OP_ADDI, 3, 3, 0, 8'h02, 0);
    // Taken skip with a long gap so the victim arrives while the kill is pending
    queue_instr(OP_SKIPEQ, 1, 2, 2, 8'h00, 3);
    queue_instr(OP_ADDI, 3, 3, 0, 8'h09, 6);
    queue_instr(OP_ADDI, 0, 0, 0, 8'h01, 0);
    // Taken skip with a one cycle gap so the victim enters as the skip leaves EX
    queue_instr(OP_SKIPEQ, 2, 0, 0, 8'h00, 3);
    queue_instr(OP_SUB, 1, 1, 0, 8'h00, 1);
    // A killed skip must not kill the one after it
    queue_instr(OP_SKIPEQ, 3, 1, 1, 8'h00, 2);
    queue_instr(OP_SKIPEQ, 0, 2, 2, 8'h00, 0);
    queue_instr(OP_ADDI, 2, 2, 0, 8'h03, 0);
    queue_instr(OP_ADD, 3, 2, 1, 8'h00, 0);
    issue_and_drain();
  endtask

  task automatic random_program();
    logic [31:0] r;
    bp_enable = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      queue_instr(opcode_t'(r[1:0]), r[3:2], r[5:4], r[7:6], r[15:8],
                  (r[17:16] == 2'b00) ? int'(r[19:18]) : 0);
    end
    issue_and_drain();
    bp_enable = 1'b0;
  endtask

  // Random retire back-pressure in the random test and always ready elsewhere
  initial begin
    forever begin
      @(posedge clk);
      #2;
      if (bp_enable) begin
        retire_ready_i = (($random(seed) & 3) != 0);
      end else begin
        retire_ready_i = 1'b1;
      end
    end
  end

  // Compare at every retire transfer with outputs sampled mid-cycle
  initial begin
    retire_rec_t rec;
    forever begin
      @(negedge clk);
      if (rst_n && retire_valid_o && retire_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected retire at %0t with no instruction outstanding", $time);
          err_count++;
        end else begin
          rec = exp_q.pop_front();
          if (retire_op_o !== rec.op) begin
            $display("[FAIL] %0t retire_op_o: got %h, expected %h", $time, retire_op_o, rec.op);
            err_count++;
          end
          if (retire_rd_o !== rec.rd) begin
            $display("[FAIL] %0t retire_rd_o: got %h, expected %h", $time, retire_rd_o, rec.rd);
            err_count++;
          end
          if (retire_value_o !== rec.value) begin
            $display("[FAIL] %0t retire_value_o: got %h, expected %h",
                     $time, retire_value_o, rec.value);
            err_count++;
          end
        end
      end
    end
  end

  initial begin
    int wait_cycles;
    int errs;
    in_valid_i     = 1'b0;
    in_instr_i     = '0;
    retire_ready_i = 1'b1;
    bp_enable      = 1'b0;
    timed_out      = 1'b0;
    model_skip     = 1'b0;
    err_count      = 0;
    tests_run      = 0;
    tests_bad      = 0;
    for (int i = 0; i < NREG; i++) begin
      model_regs[i] = '0;
    end
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 50) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset never released");
      timed_out = 1'b1;
    end
    errs = err_count;
    if (!timed_out) begin
      reset_readback();
      report_test("reset state", errs);
    end
    errs = err_count;
    if (!timed_out) begin
      independent_stream();
      report_test("independent stream", errs);
    end
    errs = err_count;
    if (!timed_out) begin
      dependent_chain();
      report_test("dependent chain", errs);
    end
    errs = err_count;
    if (!timed_out) begin
      skip_sequences();
      report_test("skips", errs);
    end
    errs = err_count;
    if (!timed_out) begin
      random_program();
      report_test("random program", errs);
    end
    // A few idle cycles to catch stray retires
    repeat (5) @(posedge clk);
    $display("Summary: %0d tests run, %0d ok, %0d with errors, %0d check errors",
             tests_run, tests_run - tests_bad, tests_bad, err_count);
    if (err_count == 0 && tests_bad == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS  = 20.0,
  parameter int  RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset held low for RST_CYCLES edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: build.f
logic/pipe_pkg.sv
logic/pipe_ctrl_if.sv
logic/pipe_ctrl.sv
logic/pipe_data.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/exec_stage.sv
logic/pipe_top.sv
bench/tb_clock.sv
bench/pipe_tb.sv

// File: logic/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage
  import pipe_pkg::*;
(
  input  wire id_ex_t ex_i,
  output ex_wb_t      ex_o,
  // Valid only together with EX occupancy
  output logic        skip_taken_o
);

  logic [XLEN-1:0] imm_ext;
  logic            operands_eq;

  // Immediate is unsigned
  assign imm_ext     = {{(XLEN-IMM_W){1'b0}}, ex_i.imm8};
  assign operands_eq = (ex_i.rs1_val == ex_i.rs2_val);

  always_comb begin
    ex_o.op        = ex_i.op;
    ex_o.rd        = ex_i.rd;
    ex_o.writes_rd = 1'b1;
    // Arithmetic wraps at XLEN bits
    case (ex_i.op)
      OP_ADD: begin
        ex_o.result = ex_i.rs1_val + ex_i.rs2_val;
      end
      OP_ADDI: begin
        ex_o.result = ex_i.rs1_val + imm_ext;
      end
      OP_SUB: begin
        ex_o.result = ex_i.rs1_val - ex_i.rs2_val;
      end
      OP_SKIPEQ: begin
        // Report the outcome, no register write
        ex_o.result    = {{(XLEN-1){1'b0}}, operands_eq};
        ex_o.writes_rd = 1'b0;
      end
      default: begin
        ex_o.result    = '0;
        ex_o.writes_rd = 1'b0;
      end
    endcase
  end

  assign skip_taken_o = (ex_i.op == OP_SKIPEQ) && operands_eq;

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
  import pipe_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Instruction waiting in ID
  input  wire instr_t           id_instr_i,

  // In-flight destinations
  input  wire logic [REG_W-1:0] ex_rd_i,
  input  wire logic             ex_writes_i,
  input  wire logic [REG_W-1:0] wb_rd_i,
  input  wire logic             wb_writes_i,

  // Skip outcome of the EX instruction
  input  wire logic             ex_skip_taken_i,
  // Input port transfer this cycle
  input  wire logic             in_fire_i,

  pipe_ctrl_if.data             id_if,
  pipe_ctrl_if.data             ex_if,
  pipe_ctrl_if.data             wb_if,

  output logic                  id_stall_o,
  output logic                  id_flush_o,
  output logic                  id_bubble_o,
  output logic                  ex_bubble_o
);

  logic uses_rs2;
  logic ex_hit;
  logic wb_hit;
  logic raw;
  logic skip_xfer;
  logic kill_id;
  logic kill_input;
  logic skip_pending;

  // ADDI has an immediate in place of a second source
  assign uses_rs2 = (id_instr_i.op != OP_ADDI);

  // Writer still in flight, no forwarding so ID must wait
  assign ex_hit = ex_if.valid && ex_writes_i &&
                  ((id_instr_i.rs1 == ex_rd_i) || (uses_rs2 && id_instr_i.rs2 == ex_rd_i));
  assign wb_hit = wb_if.valid && wb_writes_i &&
                  ((id_instr_i.rs1 == wb_rd_i) || (uses_rs2 && id_instr_i.rs2 == wb_rd_i));
  assign raw    = id_if.valid && (ex_hit || wb_hit);

  // Taken skip leaving EX this edge
  assign skip_xfer  = wb_if.advance && ex_skip_taken_i;
  // Next instruction already in ID
  assign kill_id    = skip_xfer && id_if.valid;
  // Next instruction not yet in ID, drop whatever enters next
  assign kill_input = skip_pending || (skip_xfer && !id_if.valid);

  assign id_stall_o  = raw;
  assign id_flush_o  = kill_id;
  assign id_bubble_o = kill_input;
  // Killed ID entry must not slip into EX on the same edge
  assign ex_bubble_o = raw || kill_id;

  // Pending kill stays armed until an input transfer consumes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skip_pending <= 1'b0;
    end else begin
      skip_pending <= kill_input && !in_fire_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/pipe_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,

  // Upstream side
  input  wire logic valid_i,
  output logic      ready_o,

  // Downstream side
  input  wire logic ready_i,

  // Requests from the hazard unit
  input  wire logic stall_i,
  input  wire logic flush_i,
  input  wire logic bubble_i,

  // Strobes and occupancy for this boundary
  pipe_ctrl_if.ctrl ctrl
);

  logic stage_valid;
  logic can_accept;

  // Stall wins over everything except flush
  // A full stage only takes new data when downstream drains it this edge
  assign can_accept = !stall_i && (!stage_valid || ready_i);

  // Upstream may hand over only when the stage really takes it
  assign ready_o = can_accept && !flush_i;

  // Strobes are mutually exclusive, flush first, then bubble, then advance
  always_comb begin
    ctrl.flush   = flush_i;
    ctrl.bubble  = can_accept && bubble_i && !flush_i;
    ctrl.advance = can_accept && valid_i && !bubble_i && !flush_i;
  end

  // Valid tracking follows the same priority
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else if (flush_i) begin
      stage_valid <= 1'b0;
    end else if (can_accept) begin
      // Bubble drops the incoming entry, otherwise take upstream valid
      stage_valid <= valid_i && !bubble_i;
    end
  end

  assign ctrl.valid = stage_valid;

endmodule

`default_nettype wire

// File: logic/pipe_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pipe_ctrl_if;

  // Stage occupancy after the boundary register
  logic valid;
  // Load strobe, data registers take their input
  logic advance;
  // Kill strobes, data registers clear
  logic flush;
  logic bubble;

  // Driven by the boundary controller
  modport ctrl(output valid, output advance, output flush, output bubble);

  // Observed by data registers and the hazard unit
  modport data(input valid, input advance, input flush, input bubble);

endinterface

`default_nettype wire

// File: logic/pipe_data.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_data #(
  // Payload carried across this boundary
  parameter type T = logic [15:0]
) (
  input  wire logic clk,
  input  wire logic rst_n,

  input  wire T     data_i,
  output T          data_o,

  // Strobes from this boundary's controller
  pipe_ctrl_if.data ctrl
);

  // Cleared payload reads as all zeros downstream
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_o <= '0;
    end else if (ctrl.flush || ctrl.bubble) begin
      // Killed or empty slot
      data_o <= '0;
    end else if (ctrl.advance) begin
      data_o <= data_i;
    end
    // Hold otherwise, keeps the payload stable under back-pressure
  end

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // Datapath width
  localparam int XLEN  = 16;
  // Architectural register count and index width
  localparam int NREG  = 4;
  localparam int REG_W = 2;
  // Immediate field width, zero-extended to XLEN in EX
  localparam int IMM_W = 8;

  // Two-bit operation codes
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_ADDI   = 2'd1,
    OP_SUB    = 2'd2,
    OP_SKIPEQ = 2'd3
  } opcode_t;

  // Input instruction word, also held as the ID payload
  // Fields from MSB down: op, rd, rs1, rs2, imm8
  typedef struct packed {
    opcode_t          op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [IMM_W-1:0] imm8;
  } instr_t;

  // ID to EX payload
  // Operand values are captured from the register file at the ID->EX transfer
  typedef struct packed {
    opcode_t          op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  rs1_val;
    logic [XLEN-1:0]  rs2_val;
    logic [IMM_W-1:0] imm8;
  } id_ex_t;

  // EX to WB payload
  // For a skip, result is the taken flag and writes_rd stays low
  typedef struct packed {
    opcode_t          op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  result;
    logic             writes_rd;
  } ex_wb_t;

endpackage

`default_nettype wire

// File: logic/pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_top
  import pipe_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Instruction input, valid/ready
  input  wire logic             in_valid_i,
  input  wire instr_t           in_instr_i,
  output logic                  in_ready_o,

  // Retire port, valid/ready
  output logic                  retire_valid_o,
  output opcode_t               retire_op_o,
  output logic      [REG_W-1:0] retire_rd_o,
  output logic      [XLEN-1:0]  retire_value_o,
  input  wire logic             retire_ready_i
);

  // Stage payloads, _d feeds a boundary and _q leaves it
  instr_t          id_q;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;
  ex_wb_t          ex_wb_d;
  ex_wb_t          wb_q;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            skip_taken;

  // Hazard requests
  logic            id_stall;
  logic            id_flush;
  logic            id_bubble;
  logic            ex_bubble;

  // Ready chain, WB back to the input port
  logic            id_ready;
  logic            ex_ready;
  logic            wb_ready;

  logic            in_fire;
  logic            retire_fire;

  pipe_ctrl_if b_id_if ();
  pipe_ctrl_if b_ex_if ();
  pipe_ctrl_if b_wb_if ();

  // Input port into ID
  pipe_ctrl u_id_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (in_valid_i),
    .ready_o  (id_ready),
    .ready_i  (ex_ready),
    .stall_i  (id_stall),
    .flush_i  (id_flush),
    .bubble_i (id_bubble),
    .ctrl     (b_id_if)
  );

  pipe_data #(.T(instr_t)) u_id_data (
    .clk    (clk),
    .rst_n  (rst_n),
    .data_i (in_instr_i),
    .data_o (id_q),
    .ctrl   (b_id_if)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_i    (id_q.rs1),
    .rs2_i    (id_q.rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (retire_fire && wb_q.writes_rd),
    .rd_i     (wb_q.rd),
    .wdata_i  (wb_q.result)
  );

  // Decode, operands read in ID
  assign id_ex_d = '{op: id_q.op, rd: id_q.rd, rs1_val: rs1_data,
                     rs2_val: rs2_data, imm8: id_q.imm8};

  // ID into EX, only the hazard unit bubbles here
  pipe_ctrl u_ex_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (b_id_if.valid),
    .ready_o  (ex_ready),
    .ready_i  (wb_ready),
    .stall_i  (1'b0),
    .flush_i  (1'b0),
    .bubble_i (ex_bubble),
    .ctrl     (b_ex_if)
  );

  pipe_data #(.T(id_ex_t)) u_ex_data (
    .clk    (clk),
    .rst_n  (rst_n),
    .data_i (id_ex_d),
    .data_o (id_ex_q),
    .ctrl   (b_ex_if)
  );

  exec_stage u_exec (
    .ex_i         (id_ex_q),
    .ex_o         (ex_wb_d),
    .skip_taken_o (skip_taken)
  );

  // EX into WB, held only by retire back-pressure
  pipe_ctrl u_wb_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (b_ex_if.valid),
    .ready_o  (wb_ready),
    .ready_i  (retire_ready_i),
    .stall_i  (1'b0),
    .flush_i  (1'b0),
    .bubble_i (1'b0),
    .ctrl     (b_wb_if)
  );

  pipe_data #(.T(ex_wb_t)) u_wb_data (
    .clk    (clk),
    .rst_n  (rst_n),
    .data_i (ex_wb_d),
    .data_o (wb_q),
    .ctrl   (b_wb_if)
  );

  hazard_unit u_hazard (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_instr_i      (id_q),
    .ex_rd_i         (ex_wb_d.rd),
    .ex_writes_i     (ex_wb_d.writes_rd),
    .wb_rd_i         (wb_q.rd),
    .wb_writes_i     (wb_q.writes_rd),
    .ex_skip_taken_i (skip_taken),
    .in_fire_i       (in_fire),
    .id_if           (b_id_if),
    .ex_if           (b_ex_if),
    .wb_if           (b_wb_if),
    .id_stall_o      (id_stall),
    .id_flush_o      (id_flush),
    .id_bubble_o     (id_bubble),
    .ex_bubble_o     (ex_bubble)
  );

  assign in_ready_o  = id_ready;
  assign in_fire     = in_valid_i && id_ready;

  // WB register drives the retire port directly
  assign retire_valid_o = b_wb_if.valid;
  assign retire_op_o    = wb_q.op;
  assign retire_rd_o    = wb_q.rd;
  assign retire_value_o = wb_q.result;
  assign retire_fire    = retire_valid_o && retire_ready_i;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
  import pipe_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Read ports, combinational
  input  wire logic [REG_W-1:0] rs1_i,
  input  wire logic [REG_W-1:0] rs2_i,
  output logic      [XLEN-1:0]  rdata1_o,
  output logic      [XLEN-1:0]  rdata2_o,

  // Write port, taken on the retire transfer edge
  input  wire logic             we_i,
  input  wire logic [REG_W-1:0] rd_i,
  input  wire logic [XLEN-1:0]  wdata_i
);

  logic [XLEN-1:0] regs [NREG];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // No bypass, a read in the write cycle sees the old value
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire
